// File: include/his_config.svh
`ifndef HIS_CONFIG_SVH
`define HIS_CONFIG_SVH

// time-bin address width, 16 bins
`define HIS_BIN_W 4
`define HIS_BIN_NUM 16

// bin count width, counts stop at all ones
`define HIS_CNT_W 8

// width of one counter limit
`define HIS_LIM_W 8

// limit defaults, each stored as the number minus one
// 4 samples per pixel, 4 pixels per frame, 2 frames per acquisition
`define HIS_DEF_SPP 3
`define HIS_DEF_PPF 3
`define HIS_DEF_FPA 1

`endif

// File: src/his_pkg.sv
`default_nettype none

`include "his_config.svh"

package his_pkg;

    // time-bin address of one photon sample
    typedef logic [`HIS_BIN_W-1:0] bin_addr_t;

    // count held in one histogram bin
    typedef logic [`HIS_CNT_W-1:0] bin_count_t;

    // counter limit, number minus one
    typedef logic [`HIS_LIM_W-1:0] lim_t;

    // limit select of a config word, code 3 unused
    typedef enum logic [1:0] {
        CFG_SPP = 2'd0,
        CFG_PPF = 2'd1,
        CFG_FPA = 2'd2
    } cfg_sel_t;

    // config word, select on top of the limit value
    typedef struct packed {
        cfg_sel_t sel;
        lim_t     lim;
    } cfg_word_t;

endpackage

`default_nettype wire

// File: src/his_hs_rx.sv
`timescale 1ns/1ps
`default_nettype none

module his_hs_rx #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     res,
    input  logic     req,
    input  payload_t data,
    output logic     ack,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic take;

    // buffer counts as free when its item leaves in this same cycle
    // ack low means the previous transfer has fully closed
    assign take = req && !ack && (!out_valid || out_ready);

    // handshake and buffer state
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ack       <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (take) begin
                // capture and acknowledge together
                ack       <= 1'b1;
                out_valid <= 1'b1;
            end else if (!req && ack) begin
                // return to zero after requester lets go
                ack <= 1'b0;
            end
        end
    end

    // one-entry payload buffer
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= data;
        end
    end

endmodule

`default_nettype wire

// File: src/his_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "his_config.svh"

module his_cfg_regs (
    input  logic               clk,
    input  logic               res,
    input  logic               wr_valid,
    input  his_pkg::cfg_word_t wr_word,
    input  logic               acq_idle,
    output his_pkg::lim_t      spp,
    output his_pkg::lim_t      ppf,
    output his_pkg::lim_t      fpa
);

    import his_pkg::*;

    // written by the config port at any time
    lim_t spp_sh;
    lim_t ppf_sh;
    lim_t fpa_sh;

    // shadow side
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            spp_sh <= lim_t'(`HIS_DEF_SPP);
            ppf_sh <= lim_t'(`HIS_DEF_PPF);
            fpa_sh <= lim_t'(`HIS_DEF_FPA);
        end else if (wr_valid) begin
            case (wr_word.sel)
                CFG_SPP: spp_sh <= wr_word.lim;
                CFG_PPF: ppf_sh <= wr_word.lim;
                CFG_FPA: fpa_sh <= wr_word.lim;
                // code 3 dropped
                default: ;
            endcase
        end
    end

    // active side, only moves between acquisitions
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            spp <= lim_t'(`HIS_DEF_SPP);
            ppf <= lim_t'(`HIS_DEF_PPF);
            fpa <= lim_t'(`HIS_DEF_FPA);
        end else if (acq_idle) begin
            spp <= spp_sh;
            ppf <= ppf_sh;
            fpa <= fpa_sh;
        end
    end

endmodule

`default_nettype wire

// File: src/his_frame_seq.sv
`timescale 1ns/1ps
`default_nettype none

module his_frame_seq (
    input  logic          clk,
    input  logic          res,
    input  logic          samp_done,
    input  his_pkg::lim_t spp,
    input  his_pkg::lim_t ppf,
    input  his_pkg::lim_t fpa,
    input  logic          rd_busy,
    output logic          wr_bank,
    output logic          hold,
    output logic          acq_done,
    output logic          acq_idle
);

    import his_pkg::*;

    // samples in pixel, pixels in frame, frames in acquisition
    lim_t spp_cnt;
    lim_t ppf_cnt;
    lim_t fpa_cnt;
    logic spp_wrap;
    logic ppf_wrap;
    logic fpa_wrap;
    logic acq_end;

    assign spp_wrap = (spp_cnt == spp);
    assign ppf_wrap = (ppf_cnt == ppf);
    assign fpa_wrap = (fpa_cnt == fpa);

    // last sample of the last pixel of the last frame
    assign acq_end = samp_done && spp_wrap && ppf_wrap && fpa_wrap;

    // nested counters, each carry ripples outward
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            spp_cnt <= '0;
            ppf_cnt <= '0;
            fpa_cnt <= '0;
        end else if (samp_done) begin
            if (!spp_wrap) begin
                spp_cnt <= spp_cnt + 1'b1;
            end else begin
                spp_cnt <= '0;
                if (!ppf_wrap) begin
                    ppf_cnt <= ppf_cnt + 1'b1;
                end else begin
                    ppf_cnt <= '0;
                    if (!fpa_wrap) begin
                        fpa_cnt <= fpa_cnt + 1'b1;
                    end else begin
                        fpa_cnt <= '0;
                    end
                end
            end
        end
    end

    // bank swap, or stall intake while the old bank still drains
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wr_bank  <= 1'b0;
            hold     <= 1'b0;
            acq_done <= 1'b0;
        end else begin
            acq_done <= 1'b0;
            if ((acq_end || hold) && !rd_busy) begin
                wr_bank  <= !wr_bank;
                acq_done <= 1'b1;
                hold     <= 1'b0;
            end else if (acq_end) begin
                hold <= 1'b1;
            end
        end
    end

    // between acquisitions, new limits may be loaded
    assign acq_idle = (spp_cnt == '0) && (ppf_cnt == '0) && (fpa_cnt == '0) && !hold;

endmodule

`default_nettype wire

// File: src/his_accum.sv
`timescale 1ns/1ps
`default_nettype none

`include "his_config.svh"

module his_accum (
    input  logic                clk,
    input  logic                res,
    input  logic                samp_valid,
    input  his_pkg::bin_addr_t  samp_bin,
    output logic                samp_ready,
    output logic                samp_done,
    input  logic                wr_bank,
    input  logic                hold,
    input  his_pkg::bin_addr_t  rd_addr,
    input  logic                rd_clear,
    output his_pkg::bin_count_t rd_data
);

    import his_pkg::*;

    // two banks of bin counts, ping-pong
    bin_count_t mem [0:1][0:`HIS_BIN_NUM-1];

    // stage 1 reads, stage 2 writes
    logic       s1_valid;
    bin_addr_t  s1_bin;
    logic       s2_valid;
    bin_addr_t  s2_bin;
    bin_count_t s2_count;
    bin_count_t s2_next;
    logic       accept;

    // one sample in flight at a time
    assign samp_ready = !s1_valid && !s2_valid && !hold;
    assign accept     = samp_valid && samp_ready;
    assign samp_done  = s2_valid;

    // saturating increment
    assign s2_next = (s2_count == '1) ? s2_count : s2_count + 1'b1;

    // pipeline valid bits
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
        end
    end

    // bin address and read count along the pipeline
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_bin <= samp_bin;
        end
        if (s1_valid) begin
            s2_bin   <= s1_bin;
            s2_count <= mem[wr_bank][s1_bin];
        end
    end

    // wr_bank cannot change while a sample is in flight
    // read port always sits on the other bank
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < `HIS_BIN_NUM; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else begin
            if (s2_valid) begin
                mem[wr_bank][s2_bin] <= s2_next;
            end
            if (rd_clear) begin
                mem[!wr_bank][rd_addr] <= '0;
            end
        end
    end

    // finished bank, direct read
    assign rd_data = mem[!wr_bank][rd_addr];

endmodule

`default_nettype wire

// File: src/his_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "his_config.svh"

module his_readout (
    input  logic                clk,
    input  logic                res,
    input  logic                acq_done,
    output his_pkg::bin_addr_t  rd_addr,
    output logic                rd_clear,
    input  his_pkg::bin_count_t rd_data,
    output logic                rd_busy,
    output logic                out_req,
    output his_pkg::bin_addr_t  out_bin,
    output his_pkg::bin_count_t out_count,
    input  logic                out_ack
);

    import his_pkg::*;

    typedef enum logic [1:0] {
        RO_IDLE,
        RO_READ,
        RO_REQ,
        RO_ACK_LOW
    } ro_state_t;

    ro_state_t state;
    bin_addr_t addr;

    // walk bins 0 to last, one handshake per bin
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= RO_IDLE;
            addr    <= '0;
            out_req <= 1'b0;
        end else begin
            case (state)
                RO_IDLE: begin
                    addr <= '0;
                    if (acq_done) begin
                        state <= RO_READ;
                    end
                end
                RO_READ: begin
                    out_req <= 1'b1;
                    state   <= RO_REQ;
                end
                RO_REQ: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= RO_ACK_LOW;
                    end
                end
                RO_ACK_LOW: begin
                    // receiver must return to zero before next bin
                    if (!out_ack) begin
                        if (addr == bin_addr_t'(`HIS_BIN_NUM - 1)) begin
                            state <= RO_IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= RO_READ;
                        end
                    end
                end
                default: state <= RO_IDLE;
            endcase
        end
    end

    // count held stable while out_req is up
    always_ff @(posedge clk) begin
        if (state == RO_READ) begin
            out_count <= rd_data;
        end
    end

    assign rd_addr  = addr;
    assign out_bin  = addr;
    // bin zeroed in the cycle its word is acknowledged
    assign rd_clear = (state == RO_REQ) && out_ack;
    assign rd_busy  = (state != RO_IDLE);

endmodule

`default_nettype wire

// File: src/his_top.sv
`timescale 1ns/1ps
`default_nettype none

module his_top (
    input  logic                clk,
    input  logic                res,
    input  logic                samp_req,
    input  his_pkg::bin_addr_t  samp_bin,
    output logic                samp_ack,
    input  logic                cfg_req,
    input  his_pkg::cfg_word_t  cfg_data,
    output logic                cfg_ack,
    output logic                out_req,
    output his_pkg::bin_addr_t  out_bin,
    output his_pkg::bin_count_t out_count,
    input  logic                out_ack,
    output logic                his_num
);

    import his_pkg::*;

    // sample path
    logic       samp_valid;
    bin_addr_t  samp_data;
    logic       samp_ready;
    logic       samp_done;

    // config path
    logic       cfg_valid;
    cfg_word_t  cfg_word;
    lim_t       spp;
    lim_t       ppf;
    lim_t       fpa;
    logic       acq_idle;

    // sequencing and readout
    logic       hold;
    logic       acq_done;
    logic       rd_busy;
    bin_addr_t  rd_addr;
    logic       rd_clear;
    bin_count_t rd_data;

    his_hs_rx #(.payload_t(bin_addr_t)) u_samp_rx (
        .clk(clk), .res(res), .req(samp_req), .data(samp_bin), .ack(samp_ack),
        .out_valid(samp_valid), .out_data(samp_data), .out_ready(samp_ready)
    );

    // config registers take a word every cycle
    his_hs_rx #(.payload_t(cfg_word_t)) u_cfg_rx (
        .clk(clk), .res(res), .req(cfg_req), .data(cfg_data), .ack(cfg_ack),
        .out_valid(cfg_valid), .out_data(cfg_word), .out_ready(1'b1)
    );

    his_cfg_regs u_cfg_regs (
        .clk(clk), .res(res), .wr_valid(cfg_valid), .wr_word(cfg_word),
        .acq_idle(acq_idle), .spp(spp), .ppf(ppf), .fpa(fpa)
    );

    // his_num is the bank being filled
    his_frame_seq u_frame_seq (
        .clk(clk), .res(res), .samp_done(samp_done), .spp(spp), .ppf(ppf), .fpa(fpa),
        .rd_busy(rd_busy), .wr_bank(his_num), .hold(hold), .acq_done(acq_done),
        .acq_idle(acq_idle)
    );

    his_accum u_accum (
        .clk(clk), .res(res), .samp_valid(samp_valid), .samp_bin(samp_data),
        .samp_ready(samp_ready), .samp_done(samp_done), .wr_bank(his_num), .hold(hold),
        .rd_addr(rd_addr), .rd_clear(rd_clear), .rd_data(rd_data)
    );

    his_readout u_readout (
        .clk(clk), .res(res), .acq_done(acq_done), .rd_addr(rd_addr), .rd_clear(rd_clear),
        .rd_data(rd_data), .rd_busy(rd_busy), .out_req(out_req), .out_bin(out_bin),
        .out_count(out_count), .out_ack(out_ack)
    );

endmodule

`default_nettype wire

// File: tb/his_chk.sv
`timescale 1ns/1ps
`default_nettype none

module his_chk (
    input logic clk,
    input logic res,
    input logic samp_req,
    input logic samp_ack,
    input logic cfg_req,
    input logic cfg_ack,
    input logic out_req,
    input logic out_ack
);

    // lane 0 samples, lane 1 config, lane 2 readout
    logic [2:0] req_v;
    logic [2:0] ack_v;
    // failed assertions, summed into the testbench result
    int fail_count = 0;

    assign req_v = {out_req, cfg_req, samp_req};
    assign ack_v = {out_ack, cfg_ack, samp_ack};

    for (genvar i = 0; i < 3; i++) begin : lane
        // req stays up until ack answers
        assert property (@(posedge clk) disable iff (!res)
            req_v[i] && !ack_v[i] |=> req_v[i])
        else begin
            fail_count++;
            $error("lane %0d req dropped before ack", i);
        end

        // ack only in answer to a raised req
        assert property (@(posedge clk) disable iff (!res)
            $rose(ack_v[i]) |-> $past(req_v[i]))
        else begin
            fail_count++;
            $error("lane %0d ack rose without req", i);
        end

        // return to zero, ack follows req down
        assert property (@(posedge clk) disable iff (!res)
            $fell(ack_v[i]) |-> !$past(req_v[i]))
        else begin
            fail_count++;
            $error("lane %0d ack fell while req still high", i);
        end
    end

endmodule

bind his_top his_chk u_chk (
    .clk(clk), .res(res), .samp_req(samp_req), .samp_ack(samp_ack),
    .cfg_req(cfg_req), .cfg_ack(cfg_ack), .out_req(out_req), .out_ack(out_ack)
);

`default_nettype wire

// File: tb/his_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "his_config.svh"

module his_tb;

    import his_pkg::*;

    // samples and readout words over all tests, seven acquisitions
    localparam int TOTAL_SAMP = 32 + 32 + 300 + 4 * 4;
    localparam int TOTAL_WORDS = 7 * `HIS_BIN_NUM;
    // ten cycles a sample, twelve a word, doubled for swap stalls
    localparam int CYCLE_LIMIT = 2 * (10 * TOTAL_SAMP + 12 * TOTAL_WORDS) + 1000;

    logic       clk;
    logic       res;
    logic       samp_req;
    bin_addr_t  samp_bin;
    logic       samp_ack;
    logic       cfg_req;
    cfg_word_t  cfg_data;
    logic       cfg_ack;
    logic       out_req;
    bin_addr_t  out_bin;
    bin_count_t out_count;
    logic       out_ack;
    logic       his_num;

    // model, shadow limits and the histogram being filled
    lim_t       sh_spp;
    lim_t       sh_ppf;
    lim_t       sh_fpa;
    int         acq_len;
    int         acq_idx;
    int         in_acq;
    bin_count_t hist [`HIS_BIN_NUM];
    // finished acquisitions, 16 counts each, in readout order
    bin_count_t exp_q [$];

    int         err_count = 0;
    int         cycles = 0;
    int         words_seen = 0;
    bit         slow_rd = 1'b0;
    string      test_name = "reset";

    his_top UUT (
        .clk(clk), .res(res), .samp_req(samp_req), .samp_bin(samp_bin), .samp_ack(samp_ack),
        .cfg_req(cfg_req), .cfg_data(cfg_data), .cfg_ack(cfg_ack), .out_req(out_req),
        .out_bin(out_bin), .out_count(out_count), .out_ack(out_ack), .his_num(his_num)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    task automatic check_count(input string what, input bin_count_t exp, input bin_count_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %0d actual %0d", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bin(input string what, input bin_addr_t exp, input bin_addr_t act);
        if (act !== exp) begin
            $display("Error %s %s: expected %0d actual %0d", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bank(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s %s: expected %0b actual %0b", test_name, what, exp, act);
            err_count++;
        end
    endtask

    function automatic cfg_word_t make_cfg(input logic [1:0] sel, input int lim);
        cfg_word_t w;
        w.sel = cfg_sel_t'(sel);
        w.lim = lim_t'(lim);
        return w;
    endfunction

    // one four-phase write on the config port
    task automatic write_cfg(input cfg_word_t w);
        @(posedge clk);
        cfg_req  <= 1'b1;
        cfg_data <= w;
        @(negedge clk);
        while (!cfg_ack) begin
            @(negedge clk);
        end
        @(posedge clk);
        cfg_req <= 1'b0;
        @(negedge clk);
        while (cfg_ack) begin
            @(negedge clk);
        end
        // code 3 selects nothing
        case (w.sel)
            CFG_SPP: sh_spp = w.lim;
            CFG_PPF: sh_ppf = w.lim;
            CFG_FPA: sh_fpa = w.lim;
            default: ;
        endcase
    endtask

    // one sample handshake, then the model update
    task automatic send_sample(input bin_addr_t b);
        if (in_acq == 0) begin
            // shadow limits load at the start of an acquisition
            acq_len = (int'(sh_spp) + 1) * (int'(sh_ppf) + 1) * (int'(sh_fpa) + 1);
        end
        @(posedge clk);
        samp_req <= 1'b1;
        samp_bin <= b;
        @(negedge clk);
        while (!samp_ack) begin
            @(negedge clk);
        end
        @(posedge clk);
        samp_req <= 1'b0;
        @(negedge clk);
        while (samp_ack) begin
            @(negedge clk);
        end
        // counts stop at 255
        if (hist[b] != '1) begin
            hist[b] = hist[b] + 1'b1;
        end
        in_acq++;
        // previous sample already accepted, any pending swap is done
        if (in_acq > 1) begin
            check_bank("his_num", acq_idx[0], his_num);
        end
        if (in_acq == acq_len) begin
            for (int i = 0; i < `HIS_BIN_NUM; i++) begin
                exp_q.push_back(hist[i]);
                hist[i] = '0;
            end
            acq_idx++;
            in_acq = 0;
        end
    endtask

    task automatic send_many(input int n, input int lo, input int hi);
        for (int k = 0; k < n; k++) begin
            send_sample(bin_addr_t'($urandom_range(hi, lo)));
        end
    endtask

    // readout receiver, random ack delay
    initial begin : responder
        int d;
        bin_addr_t exp_bin;
        bin_count_t exp_count;
        exp_bin = '0;
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req) begin
                d = slow_rd ? int'($urandom_range(12, 8)) : int'($urandom_range(5, 0));
                repeat (d) begin
                    @(negedge clk);
                end
                if (exp_q.size() == 0) begin
                    $display("readout sent a word with no finished acquisition behind it");
                    err_count++;
                end else begin
                    exp_count = exp_q.pop_front();
                    check_bin("readout bin", exp_bin, out_bin);
                    check_count("readout count", exp_count, out_count);
                end
                // bins come 0 to 15, wrap into the next acquisition
                exp_bin = exp_bin + 1'b1;
                @(posedge clk);
                out_ack <= 1'b1;
                @(negedge clk);
                while (out_req) begin
                    @(negedge clk);
                end
                @(posedge clk);
                out_ack <= 1'b0;
                words_seen++;
            end
        end
    end

    initial begin : watchdog
        wait (cycles >= CYCLE_LIMIT);
        $display("run hung, still busy after %0d cycles", CYCLE_LIMIT);
        $display("Errors found");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(78058));
        res = 1'b0;
        samp_req = 1'b0;
        samp_bin = '0;
        cfg_req = 1'b0;
        cfg_data = '0;
        sh_spp = lim_t'(`HIS_DEF_SPP);
        sh_ppf = lim_t'(`HIS_DEF_PPF);
        sh_fpa = lim_t'(`HIS_DEF_FPA);
        acq_len = 0;
        acq_idx = 0;
        in_acq = 0;
        for (int i = 0; i < `HIS_BIN_NUM; i++) begin
            hist[i] = '0;
        end
        repeat (10) @(posedge clk);
        res <= 1'b1;

        // default limits, 32 samples per acquisition
        test_name = "random bins";
        send_many(4, 0, 15);
        write_cfg(make_cfg(2'd3, 0));
        send_many(28, 0, 15);

        // new limits land mid-acquisition, this one stays at 32
        test_name = "mid-acquisition limit";
        send_many(5, 0, 15);
        write_cfg(make_cfg(CFG_SPP, 99));
        write_cfg(make_cfg(CFG_PPF, 2));
        write_cfg(make_cfg(CFG_FPA, 0));
        send_many(27, 0, 15);

        // 300 hits on bin 5
        test_name = "saturation";
        send_many(10, 5, 5);
        write_cfg(make_cfg(CFG_SPP, 1));
        write_cfg(make_cfg(CFG_PPF, 1));
        send_many(290, 5, 5);

        // short acquisitions against a slow receiver, bin 5 must read 0
        test_name = "slow readout";
        slow_rd = 1'b1;
        repeat (4) begin
            send_many(4, 8, 15);
        end

        wait (words_seen == acq_idx * `HIS_BIN_NUM);
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_bank("final his_num", acq_idx[0], his_num);
        $display("errors: %0d testbench, %0d assertion", err_count, UUT.u_chk.fail_count);
        if (err_count == 0 && UUT.u_chk.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
src/his_pkg.sv
src/his_hs_rx.sv
src/his_cfg_regs.sv
src/his_frame_seq.sv
src/his_accum.sv
src/his_readout.sv
src/his_top.sv
tb/his_chk.sv
tb/his_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module his_tb -f files.f -o his_sim
out=$(./obj_dir/his_sim +verilator+error+limit+100)
echo "$out"
if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
echo "simulation failed" >&2
exit 1
